// ==== Bender.yml ====
package:
  name: branch_predictor

export_include_dirs:
  - include

sources:
  - files:
      - hw/bp_pkg.sv
      - hw/bp_update_if.sv
      - hw/btb.sv
      - hw/global_branch_predictor.sv
      - hw/branch_predictor.sv

  - target: test
    files:
      - verification/branch_predictor_assert.sv
      - verification/tb_branch_predictor.sv

// ==== hw/bp_pkg.sv ====
package bp_pkg;

`include "bp_consts.svh"

    // btb geometry at the default depth
    localparam int unsigned BTB_IDX_BITS = $clog2(`BP_BTB_ENTRIES);           // index above pc[1:0]
    localparam int unsigned BTB_TAG_BITS = `BP_XLEN - BTB_IDX_BITS - 2;       // remaining upper pc bits

    // one fetch pc or branch target
    typedef logic [`BP_XLEN-1:0] bp_pc_t;

    // 2-bit saturating counter, msb is the taken prediction
    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'b00,
        CTR_WEAK_NT   = 2'b01,
        CTR_WEAK_T    = 2'b10,
        CTR_STRONG_T  = 2'b11
    } bp_ctr_e;

    // one btb line
    typedef struct packed {
        logic                    valid;   // line holds a trained branch
        logic [BTB_TAG_BITS-1:0] tag;     // upper pc bits of that branch
        bp_pc_t                  target;  // resolved target from ex
    } btb_entry_t;

endpackage

// ==== hw/bp_update_if.sv ====
`timescale 1ns/1ps

// training strobe from the ex stage, one resolved branch per valid cycle
interface bp_update_if;

    logic            valid;         // single-cycle strobe, no back-pressure
    bp_pkg::bp_pc_t  update_pc;     // pc of the resolved branch
    logic            branch_taken;  // resolved outcome
    bp_pkg::bp_pc_t  target_pc;     // resolved target address

    // driver side, loaded from the top level ports
    modport src (output valid, output update_pc, output branch_taken, output target_pc);

    // btb only needs where the branch is and where it went
    modport btb (input valid, input update_pc, input target_pc);

    // history predictor only needs the outcome
    modport ghr (input valid, input branch_taken);

endinterface

// ==== hw/branch_predictor.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

// fetch-side branch predictor top
// next pc is the btb target when the btb hits and the ghr predictor says taken
module branch_predictor (
    input  logic           clk,
    input  logic           rst_n,
    input  bp_pkg::bp_pc_t predict_pc,     // pc of the if stage
    input  logic           valid,          // branch, jal, jalr resolved in ex
    input  bp_pkg::bp_pc_t update_pc,      // pc of that branch in ex
    input  logic           branch_taken,   // its resolved outcome
    input  bp_pkg::bp_pc_t target_pc,      // its resolved target
    output bp_pkg::bp_pc_t predicted_pc    // next fetch pc, same cycle
);

    bp_update_if u_upd ();  // training bundle shared by both predictors

    logic           btb_hit;     // btb holds a line for predict_pc
    bp_pkg::bp_pc_t btb_target;  // target stored in that line
    logic           gbp_taken;   // history says taken
    bp_pkg::bp_pc_t seq_pc;      // fall-through fetch pc

    // load the ex-stage ports into the bundle
    assign u_upd.valid        = valid;
    assign u_upd.update_pc    = update_pc;
    assign u_upd.branch_taken = branch_taken;
    assign u_upd.target_pc    = target_pc;

    btb #(
        .ENTRIES    (`BP_BTB_ENTRIES)
    ) u_btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .predict_pc (predict_pc),   // lookup with the if-stage pc
        .upd        (u_upd.btb),    // trained with pc and target
        .hit        (btb_hit),
        .target     (btb_target)
    );

    global_branch_predictor #(
        .GHR_BITS   (`BP_GHR_BITS)
    ) u_gbp (
        .clk        (clk),
        .rst_n      (rst_n),
        .upd        (u_upd.ghr),    // trained with the outcome only
        .taken      (gbp_taken)
    );

    assign seq_pc = predict_pc + `BP_XLEN'd4;

    // both must agree before redirecting fetch
    assign predicted_pc = (btb_hit && gbp_taken) ? btb_target : seq_pc;

endmodule

// ==== hw/btb.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

// direct-mapped branch target buffer
// lookup is combinational, training writes at the strobe edge
module btb #(
    parameter int unsigned ENTRIES = `BP_BTB_ENTRIES  // power of two
) (
    input  logic           clk,
    input  logic           rst_n,
    input  bp_pkg::bp_pc_t predict_pc,   // if-stage fetch pc
    bp_update_if.btb       upd,          // ex-stage training strobe
    output logic           hit,          // valid line with matching tag
    output bp_pkg::bp_pc_t target        // stored target of that line
);

    localparam int unsigned IDX_W   = $clog2(ENTRIES);         // index width
    localparam int unsigned TAG_LSB = IDX_W + 2;               // tag starts above index
    localparam int unsigned TAG_W   = bp_pkg::BTB_TAG_BITS;    // stored tag width

    // the stored tag must cover every pc bit above the index
    if (ENTRIES < 2 || (1 << IDX_W) != ENTRIES) begin : g_bad_depth
        $error("btb: ENTRIES must be a power of two, at least 2");
    end
    if (`BP_XLEN - TAG_LSB > TAG_W) begin : g_bad_tag
        $error("btb: ENTRIES too small for the packed tag width");
    end

    // index from the word address bits
    function automatic logic [IDX_W-1:0] idx_of(input bp_pkg::bp_pc_t pc);
        return pc[TAG_LSB-1:2];
    endfunction

    // tag from everything above the index, zero-extended into the line
    function automatic logic [TAG_W-1:0] tag_of(input bp_pkg::bp_pc_t pc);
        bp_pkg::bp_pc_t upper;
        upper = pc >> TAG_LSB;
        return TAG_W'(upper);
    endfunction

    bp_pkg::btb_entry_t entries [ENTRIES];  // line storage

    logic [IDX_W-1:0]   rd_idx;     // lookup index
    bp_pkg::btb_entry_t rd_entry;   // line under lookup
    logic [IDX_W-1:0]   wr_idx;     // training index
    bp_pkg::btb_entry_t wr_entry;   // line to be written

    // lookup path, sees the state before any same-cycle update
    assign rd_idx   = idx_of(predict_pc);
    assign rd_entry = entries[rd_idx];
    assign hit      = rd_entry.valid && (rd_entry.tag == tag_of(predict_pc));
    assign target   = rd_entry.target;

    // training line, written regardless of outcome
    assign wr_idx = idx_of(upd.update_pc);

    always_comb begin
        wr_entry        = '0;
        wr_entry.valid  = 1'b1;                    // trained lines are always valid
        wr_entry.tag    = tag_of(upd.update_pc);   // aliasing pc evicts the old one
        wr_entry.target = upd.target_pc;
    end

    // reset invalidates every line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (upd.valid) begin
            entries[wr_idx] <= wr_entry;  // visible to lookups next cycle
        end
    end

endmodule

// ==== hw/global_branch_predictor.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

// global history predictor
// ghr indexes a pht of 2-bit counters, no pc hashing
module global_branch_predictor #(
    parameter int unsigned GHR_BITS = `BP_GHR_BITS  // history length
) (
    input  logic     clk,
    input  logic     rst_n,
    bp_update_if.ghr upd,     // ex-stage outcome strobe
    output logic     taken    // prediction for the current fetch
);

    localparam int unsigned PHT_ENTRIES = 2 ** GHR_BITS;  // one counter per history pattern

    // history shift below needs at least two bits
    if (GHR_BITS < 2) begin : g_bad_hist
        $error("global_branch_predictor: GHR_BITS must be at least 2");
    end

    // one step toward the outcome, saturating at both ends
    function automatic bp_pkg::bp_ctr_e ctr_step(input bp_pkg::bp_ctr_e ctr,
                                                 input logic outcome);
        bp_pkg::bp_ctr_e nxt;
        nxt = ctr;
        case (ctr)
            bp_pkg::CTR_STRONG_NT: nxt = outcome ? bp_pkg::CTR_WEAK_NT : bp_pkg::CTR_STRONG_NT;
            bp_pkg::CTR_WEAK_NT:   nxt = outcome ? bp_pkg::CTR_WEAK_T  : bp_pkg::CTR_STRONG_NT;
            bp_pkg::CTR_WEAK_T:    nxt = outcome ? bp_pkg::CTR_STRONG_T : bp_pkg::CTR_WEAK_NT;
            bp_pkg::CTR_STRONG_T:  nxt = outcome ? bp_pkg::CTR_STRONG_T : bp_pkg::CTR_WEAK_T;
            default:               nxt = bp_pkg::CTR_WEAK_NT;
        endcase
        return nxt;
    endfunction

    logic [GHR_BITS-1:0] ghr;                // newest outcome in bit 0
    bp_pkg::bp_ctr_e     pht [PHT_ENTRIES];  // pattern history table
    bp_pkg::bp_ctr_e     cur_ctr;            // counter selected by the ghr
    bp_pkg::bp_ctr_e     nxt_ctr;            // its value after training

    // prediction and training both use the counter under the current history
    assign cur_ctr = pht[ghr];
    assign taken   = cur_ctr[1];  // msb set means weakly or strongly taken
    assign nxt_ctr = ctr_step(cur_ctr, upd.branch_taken);

    // counters start weakly not taken so a cold table predicts fall-through
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr <= '0;
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= bp_pkg::CTR_WEAK_NT;
            end
        end else if (upd.valid) begin
            pht[ghr] <= nxt_ctr;                             // train under old history
            ghr      <= {ghr[GHR_BITS-2:0], upd.branch_taken};  // then shift outcome in
        end
    end

endmodule

// ==== include/bp_consts.svh ====
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// sizing of the fetch-side branch predictor

// pc and branch target width
`define BP_XLEN 32

// direct-mapped btb depth, power of two
`define BP_BTB_ENTRIES 64

// global history length, pht holds 2**BP_GHR_BITS counters
`define BP_GHR_BITS 8

`endif

// ==== verification/branch_predictor_assert.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

// properties on the predictor top, bound below
module branch_predictor_assert (
    input logic                    clk,
    input logic                    rst_n,
    input bp_pkg::bp_pc_t          predict_pc,
    input bp_pkg::bp_pc_t          predicted_pc,
    input logic                    valid,           // training strobe
    input bp_pkg::bp_pc_t          update_pc,       // pc written into the btb on a strobe
    input logic                    btb_hit,
    input bp_pkg::bp_pc_t          btb_target,
    input logic [`BP_GHR_BITS-1:0] ghr
);

    localparam int unsigned IDX_W = $clog2(`BP_BTB_ENTRIES);  // btb index bits above pc[1:0]

    int unsigned                fail_cnt = 0;  // assertion failures so far
    logic [`BP_BTB_ENTRIES-1:0] trained;       // lines written since reset, from the strobe alone

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
            trained <= '0;
        else if (valid)
            trained[update_pc[IDX_W+1:2]] <= 1'b1;

    // next pc comes from one of two sources only
    a_next_pc_src: assert property (@(posedge clk) disable iff (!rst_n)
        (predicted_pc == predict_pc + `BP_XLEN'd4) || (predicted_pc == btb_target))
        else begin
            $error("predicted pc is neither pc+4 nor the btb target");
            fail_cnt++;
        end

    // history only moves on a strobe
    a_ghr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !valid |=> $stable(ghr))
        else begin
            $error("ghr changed without a training strobe");
            fail_cnt++;
        end

    // a hit needs a line trained since reset
    a_hit_valid: assert property (@(posedge clk) disable iff (!rst_n)
        btb_hit |-> trained[predict_pc[IDX_W+1:2]])
        else begin
            $error("btb hit on a line with its valid bit clear");
            fail_cnt++;
        end

endmodule

bind branch_predictor branch_predictor_assert u_bp_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .predict_pc     (predict_pc),
    .predicted_pc   (predicted_pc),
    .valid          (valid),
    .update_pc      (update_pc),
    .btb_hit        (btb_hit),
    .btb_target     (btb_target),
    .ghr            (u_gbp.ghr)
);

// ==== verification/tb_branch_predictor.sv ====
`timescale 1ns/1ps

`include "bp_consts.svh"

module tb_branch_predictor;

    localparam int unsigned IDX_W   = $clog2(`BP_BTB_ENTRIES);  // btb index bits above pc[1:0]
    localparam int unsigned PHT_N   = 1 << `BP_GHR_BITS;
    localparam int unsigned RST_CYC = 3;
    localparam int unsigned LEN_RST = 100;   // cycles per test
    localparam int unsigned LEN_HIT = 16;
    localparam int unsigned LEN_ALI = 4;
    localparam int unsigned LEN_HYS = 20;
    localparam int unsigned LEN_NXT = 2;
    localparam int unsigned LEN_RND = 2000;
    localparam int unsigned TIMEOUT = (LEN_RST + LEN_HIT + LEN_ALI + LEN_HYS + LEN_NXT
                                       + LEN_RND + RST_CYC) * 2;

    localparam bit [31:0] PC_A  = 32'h0000_1040;  // index 16
    localparam bit [31:0] PC_B  = 32'h0000_1140;  // same index as a, other tag
    localparam bit [31:0] PC_U  = 32'h0000_1080;  // never trained
    localparam bit [31:0] PC_C  = 32'h0000_10c0;
    localparam bit [31:0] TGT_A = 32'h0000_2000;
    localparam bit [31:0] TGT_B = 32'h0000_3000;
    localparam bit [31:0] TGT_C = 32'h0000_4000;

    logic           clk;
    logic           rst_n;
    bp_pkg::bp_pc_t predict_pc;
    logic           valid;
    bp_pkg::bp_pc_t update_pc;
    logic           branch_taken;
    bp_pkg::bp_pc_t target_pc;
    bp_pkg::bp_pc_t predicted_pc;

    // reference tables
    logic                    m_valid  [`BP_BTB_ENTRIES];
    logic [`BP_XLEN-1:0]     m_tag    [`BP_BTB_ENTRIES];  // pc >> (IDX_W+2)
    bp_pkg::bp_pc_t          m_target [`BP_BTB_ENTRIES];
    logic [1:0]              m_ctr    [PHT_N];
    logic [`BP_GHR_BITS-1:0] m_ghr;

    integer         seed;
    int unsigned    cycle_cnt;
    int unsigned    n_checks;
    int unsigned    n_mism;
    int unsigned    test_errs;
    int unsigned    tests_ok;
    int unsigned    tests_bad;
    bp_pkg::bp_pc_t last_pred;   // dut output seen by the latest cycle
    bp_pkg::bp_pc_t pool [16];

    branch_predictor u_branch_predictor (
        .clk          (clk),
        .rst_n        (rst_n),
        .predict_pc   (predict_pc),
        .valid        (valid),
        .update_pc    (update_pc),
        .branch_taken (branch_taken),
        .target_pc    (target_pc),
        .predicted_pc (predicted_pc)
    );

    always #5 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic int unsigned index_of(input bp_pkg::bp_pc_t pc);
        return (pc >> 2) % `BP_BTB_ENTRIES;
    endfunction

    // expected next pc from the reference state
    function automatic bp_pkg::bp_pc_t model_predict(input bp_pkg::bp_pc_t pc);
        int unsigned idx;
        logic        hit;
        idx = index_of(pc);
        hit = m_valid[idx] && (m_tag[idx] == (pc >> (IDX_W + 2)));
        if (hit && m_ctr[m_ghr][1])
            return m_target[idx];
        return pc + 32'd4;
    endfunction

    function automatic void model_train(input bp_pkg::bp_pc_t pc, input logic tkn,
                                        input bp_pkg::bp_pc_t tgt);
        int unsigned idx;
        idx = index_of(pc);
        m_valid[idx]  = 1'b1;                  // written whatever the outcome
        m_tag[idx]    = pc >> (IDX_W + 2);
        m_target[idx] = tgt;
        if (tkn && m_ctr[m_ghr] != 2'd3)
            m_ctr[m_ghr] = m_ctr[m_ghr] + 2'd1;
        else if (!tkn && m_ctr[m_ghr] != 2'd0)
            m_ctr[m_ghr] = m_ctr[m_ghr] - 2'd1;
        m_ghr = {m_ghr[`BP_GHR_BITS-2:0], tkn};  // counter first, then shift
    endfunction

    // one cycle: drive at negedge, check just before posedge, train model at posedge
    task automatic run_cycle(input logic vld, input bp_pkg::bp_pc_t upc, input logic tkn,
                             input bp_pkg::bp_pc_t tgt, input bp_pkg::bp_pc_t lpc);
        bp_pkg::bp_pc_t exp_pc;
        @(negedge clk);
        valid        = vld;
        update_pc    = upc;
        branch_taken = tkn;
        target_pc    = tgt;
        predict_pc   = lpc;
        #4;
        exp_pc    = model_predict(lpc);  // old state, same-cycle update not yet seen
        last_pred = predicted_pc;
        n_checks++;
        if (predicted_pc !== exp_pc) begin
            $display("mismatch at %0t: pc %h expected %h actual %h",
                     $time, lpc, exp_pc, predicted_pc);
            test_errs++;
        end
        @(posedge clk);
        if (vld)
            model_train(upc, tkn, tgt);
    endtask

    // direct expectation from the counter and ghr rules
    task automatic expect_last(input bp_pkg::bp_pc_t exp_pc);
        n_checks++;
        if (last_pred !== exp_pc) begin
            $display("mismatch at %0t: rule expects %h actual %h", $time, exp_pc, last_pred);
            test_errs++;
        end
    endtask

    task automatic lookup(input bp_pkg::bp_pc_t lpc);
        run_cycle(1'b0, '0, 1'b0, '0, lpc);
    endtask

    task automatic close_test(input string name);
        n_mism += test_errs;
        if (test_errs == 0) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        bp_pkg::bp_pc_t rpc;
        int unsigned    sel;
        clk = 1'b0;
        rst_n = 1'b0;
        predict_pc = '0;
        valid = 1'b0;
        update_pc = '0;
        branch_taken = 1'b0;
        target_pc = '0;
        seed = 32'hbda98d83;
        cycle_cnt = 0;
        n_checks = 0;
        n_mism = 0;
        test_errs = 0;
        tests_ok = 0;
        tests_bad = 0;
        for (int i = 0; i < `BP_BTB_ENTRIES; i++)
            m_valid[i] = 1'b0;
        for (int i = 0; i < PHT_N; i++)
            m_ctr[i] = 2'd1;  // weakly not taken
        m_ghr = '0;
        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < LEN_RST; i++) begin
            rpc = $random(seed) & 32'hffff_fffc;
            lookup(rpc);
            expect_last(rpc + 32'd4);
        end
        close_test("reset_state");

        for (int i = 0; i < 12; i++)
            run_cycle(1'b1, PC_A, 1'b1, TGT_A, PC_A);  // ghr fills to all ones, ctr saturates
        lookup(PC_A);
        expect_last(TGT_A);
        lookup(PC_U);
        expect_last(PC_U + 32'd4);
        close_test("btb_hit_miss");

        run_cycle(1'b1, PC_B, 1'b1, TGT_B, PC_B);
        run_cycle(1'b1, PC_B, 1'b1, TGT_B, PC_B);
        lookup(PC_B);
        expect_last(TGT_B);
        lookup(PC_A);
        expect_last(PC_A + 32'd4);  // evicted by b
        close_test("alias_eviction");

        run_cycle(1'b1, PC_B, 1'b0, TGT_B, PC_B);  // ctr[ff] strong to weak taken
        for (int i = 0; i < 8; i++)
            run_cycle(1'b1, PC_B, 1'b1, TGT_B, PC_B);  // ghr back to ff, ctr[ff] untouched
        lookup(PC_B);
        expect_last(TGT_B);
        run_cycle(1'b1, PC_B, 1'b0, TGT_B, PC_B);  // ctr[ff] now weakly not taken
        for (int i = 0; i < 8; i++)
            run_cycle(1'b1, PC_B, 1'b1, TGT_B, PC_B);
        lookup(PC_B);
        expect_last(PC_B + 32'd4);
        close_test("counter_hysteresis");

        run_cycle(1'b1, PC_C, 1'b1, TGT_C, PC_C);
        expect_last(PC_C + 32'd4);  // update not visible yet
        lookup(PC_C);
        expect_last(TGT_C);
        close_test("update_next_cycle");

        // 12 distinct indices, last four alias the first four
        for (int i = 0; i < 16; i++)
            pool[i] = ($random(seed) & 32'hffff_ff00) | ((i % 12) << 2);
        for (int i = 0; i < LEN_RND; i++) begin
            sel = $random(seed) & 32'hf;
            rpc = pool[$random(seed) & 32'hf];
            if (($random(seed) & 7) == 0)
                rpc = $random(seed) & 32'hffff_fffc;
            run_cycle($random(seed) & 1, pool[sel], ($random(seed) & 3) != 0,
                      $random(seed) & 32'hffff_fffc, rpc);
        end
        close_test("random_mix");

        if (u_branch_predictor.u_bp_assert.fail_cnt != 0) begin
            $display("bound assertions failed %0d times", u_branch_predictor.u_bp_assert.fail_cnt);
            tests_bad++;
        end
        $display("tests passed %0d failed %0d, checks %0d, mismatches %0d",
                 tests_ok, tests_bad, n_checks, n_mism);
        if (tests_bad == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
hw/bp_pkg.sv
hw/bp_update_if.sv
hw/btb.sv
hw/global_branch_predictor.sv
hw/branch_predictor.sv
verification/branch_predictor_assert.sv
verification/tb_branch_predictor.sv
